// ==== src/uart_line_pkg.sv ====
`default_nettype none

// Serial line timing for the echo bridge
// Format is fixed at 8 data bits, no parity, LSB first
package uart_line_pkg;

    // Default bit period in clocks
    localparam int CLKS_PER_BIT_DEF = 434;

    // Samples taken per data bit spaced one eighth of a bit apart
    localparam int N_SAMPLES = 5;

    // High samples needed for a data bit to read as 1
    localparam int VOTE_MIN = 3;

    // Receiver stays deaf this many bit periods after a bad frame
    localparam int ERR_HOLDOFF_BITS = 2;

    // Stop period on transmit in bit periods
    localparam int STOP_BITS = 2;

    // Transmitter waits this long before polling an empty buffer again
    localparam int RETRY_BITS = 1;

endpackage

`default_nettype wire

// ==== src/uart_buf_pkg.sv ====
`default_nettype none

// Types shared between the serial clients and the ring buffer
package uart_buf_pkg;

    // One data byte as it sits in the buffer
    typedef logic [7:0] byte_t;

    // Default buffer depth in bytes
    localparam int DEPTH_DEF = 8;

    // Clients of the buffer
    // Also used by the arbiter for grant and last-served record
    typedef enum logic {
        PUSH = 1'b0,
        POP  = 1'b1
    } client_e;

endpackage

`default_nettype wire

// ==== src/buf_port_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// One client's four-phase link to the shared buffer
// Client raises req and the buffer answers with ack, ok and rdata
interface buf_port_if;

    logic                req;
    logic                ack;
    // Push payload held stable while req is high
    uart_buf_pkg::byte_t wdata;
    // Pop result valid while ack is high
    uart_buf_pkg::byte_t rdata;
    // Push accepted or pop data valid
    logic                ok;

    modport client (
        output req,
        output wdata,
        input  ack,
        input  rdata,
        input  ok
    );

    modport buffer (
        input  req,
        input  wdata,
        output ack,
        output rdata,
        output ok
    );

endinterface

`default_nettype wire

// ==== src/uart_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_rx #(
    parameter int CLKS_PER_BIT = uart_line_pkg::CLKS_PER_BIT_DEF
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       rx,
    output logic       rx_error,
    output logic       byte_dropped,
    buf_port_if.client push
);

    // Offsets inside one bit period
    localparam int HALF      = CLKS_PER_BIT / 2;
    localparam int EIGHTH    = CLKS_PER_BIT / 8;
    // Distance from bit centre to the outer samples
    localparam int SPAN_HALF = ((uart_line_pkg::N_SAMPLES - 1) / 2) * EIGHTH;
    // Previous centre to next first sample and last sample to stop centre
    localparam int TO_FIRST  = CLKS_PER_BIT - SPAN_HALF;
    // Last sample of one bit to first sample of the next
    localparam int BIT_GAP   = CLKS_PER_BIT - 2 * SPAN_HALF;
    localparam int HOLDOFF   = uart_line_pkg::ERR_HOLDOFF_BITS * CLKS_PER_BIT;
    localparam int TW        = $clog2(HOLDOFF + 1);
    localparam int SW        = $clog2(uart_line_pkg::N_SAMPLES + 1);

    typedef enum logic [2:0] {
        RX_IDLE,
        RX_START,
        RX_SAMPLE,
        RX_STOP,
        RX_HOLDOFF
    } rx_state_t;

    rx_state_t           state;
    logic                rx_meta;
    logic                rx_sync;
    logic [TW-1:0]       timer;
    logic [SW-1:0]       smp_cnt;
    logic [SW-1:0]       ones;
    logic [SW-1:0]       ones_next;
    logic [2:0]          bit_cnt;
    logic                bit_val;
    logic                last_sample;
    logic                stop_ok;
    logic                push_pend;
    uart_buf_pkg::byte_t shift;
    uart_buf_pkg::byte_t push_data;

    // Two-flop synchronizer that resets to the idle high level
    always_ff @(posedge clk) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    // Running vote including the sample taken this cycle
    assign ones_next   = ones + SW'(rx_sync);
    assign bit_val     = ones_next >= SW'(uart_line_pkg::VOTE_MIN);
    assign last_sample = state == RX_SAMPLE && timer == '0 &&
                         smp_cnt == SW'(uart_line_pkg::N_SAMPLES - 1);
    assign stop_ok     = state == RX_STOP && timer == '0 && rx_sync;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= RX_IDLE;
            timer    <= '0;
            smp_cnt  <= '0;
            ones     <= '0;
            bit_cnt  <= '0;
            rx_error <= 1'b0;
        end else begin
            rx_error <= 1'b0;
            if (timer != '0)
                timer <= timer - 1'b1;
            case (state)
                RX_IDLE: begin
                    // On a falling edge go check the start bit centre
                    if (!rx_sync) begin
                        timer <= TW'(HALF - 1);
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (timer == '0) begin
                        if (!rx_sync) begin
                            timer   <= TW'(TO_FIRST - 1);
                            smp_cnt <= '0;
                            ones    <= '0;
                            bit_cnt <= '0;
                            state   <= RX_SAMPLE;
                        end else begin
                            // Start pulse too short
                            rx_error <= 1'b1;
                            timer    <= TW'(HOLDOFF - 1);
                            state    <= RX_HOLDOFF;
                        end
                    end
                end
                RX_SAMPLE: begin
                    if (timer == '0) begin
                        if (last_sample) begin
                            smp_cnt <= '0;
                            ones    <= '0;
                            if (bit_cnt == 3'd7) begin
                                timer <= TW'(TO_FIRST - 1);
                                state <= RX_STOP;
                            end else begin
                                bit_cnt <= bit_cnt + 1'b1;
                                timer   <= TW'(BIT_GAP - 1);
                            end
                        end else begin
                            smp_cnt <= smp_cnt + 1'b1;
                            ones    <= ones_next;
                            timer   <= TW'(EIGHTH - 1);
                        end
                    end
                end
                RX_STOP: begin
                    if (timer == '0) begin
                        if (rx_sync) begin
                            state <= RX_IDLE;
                        end else begin
                            // Framing error because the stop bit is low
                            rx_error <= 1'b1;
                            timer    <= TW'(HOLDOFF - 1);
                            state    <= RX_HOLDOFF;
                        end
                    end
                end
                RX_HOLDOFF: begin
                    if (timer == '0)
                        state <= RX_IDLE;
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // Majority result shifted in LSB first
    always_ff @(posedge clk) begin
        if (last_sample)
            shift <= {bit_val, shift[7:1]};
        if (stop_ok)
            push_data <= shift;
    end

    // Push handshake runs beside the FSM so reception never waits on it
    always_ff @(posedge clk) begin
        if (rst) begin
            push_pend    <= 1'b0;
            push.req     <= 1'b0;
            byte_dropped <= 1'b0;
        end else begin
            byte_dropped <= 1'b0;
            if (stop_ok) begin
                push_pend <= 1'b1;
            end else if (push_pend && !push.req && !push.ack) begin
                push.req  <= 1'b1;
                push_pend <= 1'b0;
            end
            // Buffer full when ok comes back low
            if (push.req && push.ack) begin
                push.req     <= 1'b0;
                byte_dropped <= !push.ok;
            end
        end
    end

    assign push.wdata = push_data;

endmodule

`default_nettype wire

// ==== src/uart_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
    parameter int CLKS_PER_BIT = uart_line_pkg::CLKS_PER_BIT_DEF
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       tx_pause,
    output logic       tx,
    buf_port_if.client pop
);

    localparam int STOP_LEN  = uart_line_pkg::STOP_BITS * CLKS_PER_BIT;
    localparam int RETRY_LEN = uart_line_pkg::RETRY_BITS * CLKS_PER_BIT;
    localparam int TMAX      = (STOP_LEN > RETRY_LEN) ? STOP_LEN : RETRY_LEN;
    localparam int TW        = $clog2(TMAX + 1);

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_REQ,
        TX_SEND,
        TX_STOP,
        TX_RETRY
    } tx_state_t;

    tx_state_t           state;
    logic [TW-1:0]       timer;
    // Counts data bits already on the line and reaches 8 before the stop period
    logic [3:0]          bit_cnt;
    logic                load;
    logic                shift_now;
    uart_buf_pkg::byte_t data_q;

    assign load      = state == TX_REQ && pop.ack && pop.ok;
    assign shift_now = state == TX_SEND && timer == '0 && bit_cnt != 4'd8;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= TX_IDLE;
            timer   <= '0;
            bit_cnt <= '0;
            tx      <= 1'b1;
            pop.req <= 1'b0;
        end else begin
            if (timer != '0)
                timer <= timer - 1'b1;
            case (state)
                TX_IDLE: begin
                    // Pause only checked here between frames
                    if (!tx_pause && !pop.ack) begin
                        pop.req <= 1'b1;
                        state   <= TX_REQ;
                    end
                end
                TX_REQ: begin
                    if (pop.ack) begin
                        pop.req <= 1'b0;
                        if (pop.ok) begin
                            // Start bit goes out right away
                            tx      <= 1'b0;
                            bit_cnt <= '0;
                            timer   <= TW'(CLKS_PER_BIT - 1);
                            state   <= TX_SEND;
                        end else begin
                            // Buffer empty so poll again later
                            timer <= TW'(RETRY_LEN - 1);
                            state <= TX_RETRY;
                        end
                    end
                end
                TX_SEND: begin
                    if (timer == '0) begin
                        if (bit_cnt == 4'd8) begin
                            tx    <= 1'b1;
                            timer <= TW'(STOP_LEN - 1);
                            state <= TX_STOP;
                        end else begin
                            tx      <= data_q[0];
                            bit_cnt <= bit_cnt + 1'b1;
                            timer   <= TW'(CLKS_PER_BIT - 1);
                        end
                    end
                end
                TX_STOP, TX_RETRY: begin
                    if (timer == '0)
                        state <= TX_IDLE;
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // Byte from the buffer shifted out LSB first
    always_ff @(posedge clk) begin
        if (load)
            data_q <= pop.rdata;
        else if (shift_now)
            data_q <= {1'b0, data_q[7:1]};
    end

    // Pop carries no payload toward the buffer
    assign pop.wdata = '0;

endmodule

`default_nettype wire

// ==== src/echo_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module echo_buffer #(
    parameter int DEPTH = uart_buf_pkg::DEPTH_DEF
) (
    input  logic       clk,
    input  logic       rst,
    buf_port_if.buffer push,
    buf_port_if.buffer pop
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    uart_buf_pkg::byte_t     mem [DEPTH];
    logic [AW-1:0]           wr_ptr;
    logic [AW-1:0]           rd_ptr;
    logic [CW-1:0]           count;
    logic                    full;
    logic                    empty;
    logic                    push_pend;
    logic                    pop_pend;
    logic                    serve;
    logic                    do_write;
    logic                    do_read;
    uart_buf_pkg::client_e   grant;
    uart_buf_pkg::client_e   last_served;

    // Ring pointer advance with wrap at DEPTH
    function automatic logic [AW-1:0] ptr_next(input logic [AW-1:0] p);
        if (p == AW'(DEPTH - 1))
            return '0;
        return p + 1'b1;
    endfunction

    assign full  = count == CW'(DEPTH);
    assign empty = count == '0;

    // A request is pending until it has been acked
    assign push_pend = push.req && !push.ack;
    assign pop_pend  = pop.req && !pop.ack;
    assign serve     = push_pend || pop_pend;

    // Round robin where the client not served last wins a tie
    always_comb begin
        if (push_pend && pop_pend) begin
            if (last_served == uart_buf_pkg::PUSH)
                grant = uart_buf_pkg::POP;
            else
                grant = uart_buf_pkg::PUSH;
        end else if (push_pend) begin
            grant = uart_buf_pkg::PUSH;
        end else begin
            grant = uart_buf_pkg::POP;
        end
    end

    assign do_write = serve && grant == uart_buf_pkg::PUSH && !full;
    assign do_read  = serve && grant == uart_buf_pkg::POP && !empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            last_served <= uart_buf_pkg::POP;
            push.ack    <= 1'b0;
            push.ok     <= 1'b0;
            pop.ack     <= 1'b0;
            pop.ok      <= 1'b0;
        end else begin
            // Ack falls the cycle after req falls
            if (push.ack && !push.req)
                push.ack <= 1'b0;
            if (pop.ack && !pop.req)
                pop.ack <= 1'b0;
            if (serve) begin
                last_served <= grant;
                if (grant == uart_buf_pkg::PUSH) begin
                    push.ack <= 1'b1;
                    push.ok  <= !full;
                end else begin
                    pop.ack <= 1'b1;
                    pop.ok  <= !empty;
                end
            end
            // One access per cycle so count moves by one at most
            if (do_write) begin
                wr_ptr <= ptr_next(wr_ptr);
                count  <= count + 1'b1;
            end else if (do_read) begin
                rd_ptr <= ptr_next(rd_ptr);
                count  <= count - 1'b1;
            end
        end
    end

    // Storage and read data
    always_ff @(posedge clk) begin
        if (do_write)
            mem[wr_ptr] <= push.wdata;
        if (do_read)
            pop.rdata <= mem[rd_ptr];
    end

    // Push side gets no data back
    assign push.rdata = '0;

endmodule

`default_nettype wire

// ==== src/uart_echo_top.sv ====
`timescale 1ns/1ps
`default_nettype none

// Echo bridge that sends rx bytes through the ring buffer and back out on tx
module uart_echo_top #(
    parameter int CLKS_PER_BIT = uart_line_pkg::CLKS_PER_BIT_DEF,
    parameter int DEPTH        = uart_buf_pkg::DEPTH_DEF
) (
    input  logic clk,
    input  logic rst,
    input  logic rx,
    input  logic tx_pause,
    output logic tx,
    output logic rx_error,
    output logic byte_dropped
);

    // Receiver to buffer
    buf_port_if push_port ();
    // Transmitter to buffer
    buf_port_if pop_port ();

    uart_rx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_rx (
        .clk          (clk),
        .rst          (rst),
        .rx           (rx),
        .rx_error     (rx_error),
        .byte_dropped (byte_dropped),
        .push         (push_port.client)
    );

    uart_tx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_tx (
        .clk      (clk),
        .rst      (rst),
        .tx_pause (tx_pause),
        .tx       (tx),
        .pop      (pop_port.client)
    );

    // Shared ring buffer with the arbiter
    echo_buffer #(
        .DEPTH (DEPTH)
    ) u_buf (
        .clk  (clk),
        .rst  (rst),
        .push (push_port.buffer),
        .pop  (pop_port.buffer)
    );

endmodule

`default_nettype wire

// ==== tb/uart_echo_props.sv ====
`timescale 1ns/1ps
`default_nettype none

// Handshake and line-level properties bound into the echo top level
module uart_echo_props (
    input logic clk,
    input logic rst,
    input logic push_req,
    input logic push_ack,
    input logic pop_req,
    input logic pop_ack,
    input logic tx
);

    // An ack only ever rises while its req is up
    push_ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(push_ack) |-> push_req) else $error("push ack raised without a request");
    pop_ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(pop_ack) |-> pop_req) else $error("pop ack raised without a request");

    // Client holds req until the buffer answers
    push_req_held: assert property (@(posedge clk) disable iff (rst)
        push_req && !push_ack |=> push_req) else $error("push req dropped before ack");
    pop_req_held: assert property (@(posedge clk) disable iff (rst)
        pop_req && !pop_ack |=> pop_req) else $error("pop req dropped before ack");

    // Buffer holds ack until the client lets go of req
    push_ack_held: assert property (@(posedge clk) disable iff (rst)
        push_ack && push_req |=> push_ack) else $error("push ack dropped while req high");
    pop_ack_held: assert property (@(posedge clk) disable iff (rst)
        pop_ack && pop_req |=> pop_ack) else $error("pop ack dropped while req high");

    // Transmitter asks for a byte only between frames when the line idles high
    tx_idle_high: assert property (@(posedge clk) disable iff (rst)
        pop_req |-> tx) else $error("tx low while transmitter idle");

endmodule

bind uart_echo_top uart_echo_props u_props (
    .clk      (clk),
    .rst      (rst),
    .push_req (push_port.req),
    .push_ack (push_port.ack),
    .pop_req  (pop_port.req),
    .pop_ack  (pop_port.ack),
    .tx       (tx)
);

`default_nettype wire

// ==== tb/uart_echo_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_echo_tb;

    localparam int CLKS   = 16;
    localparam int DEPTH  = 8;
    localparam int BIT_NS = CLKS * 40;
    // Frames on rx plus echoes on tx over all tests at 12 bit periods each
    localparam int FRAMES = 40;
    localparam longint WATCHDOG_NS = longint'(FRAMES * 12 + 200) * BIT_NS;

    logic clk;
    logic rst;
    logic rx;
    logic tx_pause;
    logic tx;
    logic rx_error;
    logic byte_dropped;

    uart_buf_pkg::byte_t exp_q[$];
    uart_buf_pkg::byte_t got_q[$];
    int errors       = 0;
    int tests_run    = 0;
    int tests_failed = 0;
    int err_pulses   = 0;
    int drop_pulses  = 0;

    uart_echo_top #(
        .CLKS_PER_BIT (CLKS),
        .DEPTH        (DEPTH)
    ) DUT (
        .clk          (clk),
        .rst          (rst),
        .rx           (rx),
        .tx_pause     (tx_pause),
        .tx           (tx),
        .rx_error     (rx_error),
        .byte_dropped (byte_dropped)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Pulse counters for the two status outputs
    always @(posedge clk) begin
        if (!rst && rx_error)
            err_pulses <= err_pulses + 1;
        if (!rst && byte_dropped)
            drop_pulses <= drop_pulses + 1;
    end

    // Line monitor that decodes tx at bit centres into got_q
    initial begin : tx_monitor
        uart_buf_pkg::byte_t b;
        int i;
        wait (rst === 1'b0);
        forever begin
            @(negedge clk);
            if (tx === 1'b0) begin
                repeat (CLKS / 2 - 1) @(negedge clk);
                for (i = 0; i < 8; i++) begin
                    repeat (CLKS) @(negedge clk);
                    b[i] = tx;
                end
                repeat (CLKS) @(negedge clk);
                assert (tx === 1'b1)
                else begin
                    $display("CHECK FAILED at %0d ns: stop bit low on tx", $time);
                    errors++;
                end
                got_q.push_back(b);
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: run still going after %0d ns, test sequence stuck", WATCHDOG_NS);
        $display("ERRORS FOUND");
        $finish;
    end

    task automatic check_value(input int got, input int exp, input string what);
        assert (got == exp)
        else begin
            $display("CHECK FAILED at %0d ns: %s, got 0x%0h expected 0x%0h",
                     $time, what, got, exp);
            errors++;
        end
    endtask

    // 8N1 frame on rx entered and left on a falling edge
    task automatic send_byte(input uart_buf_pkg::byte_t data, input bit stop_low,
                             input bit short_start, input int glitch_bit);
        int i;
        rx = 1'b0;
        if (short_start) begin
            // Low for a quarter bit which ends well before the start check
            repeat (CLKS / 4) @(negedge clk);
            rx = 1'b1;
        end else begin
            repeat (CLKS) @(negedge clk);
            for (i = 0; i < 8; i++) begin
                rx = data[i];
                if (i == glitch_bit) begin
                    // One clock of the wrong level at the bit centre
                    repeat (CLKS / 2) @(negedge clk);
                    rx = !data[i];
                    @(negedge clk);
                    rx = data[i];
                    repeat (CLKS / 2 - 1) @(negedge clk);
                end else begin
                    repeat (CLKS) @(negedge clk);
                end
            end
            rx = !stop_low;
            repeat (CLKS) @(negedge clk);
            rx = 1'b1;
        end
    endtask

    task automatic wait_bytes(input int n, input int max_bits);
        int cycles;
        cycles = 0;
        while (got_q.size() < n && cycles < max_bits * CLKS) begin
            @(posedge clk);
            cycles++;
        end
        if (got_q.size() < n) begin
            $display("Timed out waiting for echo on tx, %0d of %0d bytes arrived",
                     got_q.size(), n);
            errors++;
        end
        @(negedge clk);
    endtask

    // Pop matching pairs of expected and received bytes
    task automatic compare_echo(input int n, input int max_bits, input string what);
        int k;
        wait_bytes(n, max_bits);
        for (k = 0; k < n && got_q.size() > 0 && exp_q.size() > 0; k++)
            check_value(got_q.pop_front(), exp_q.pop_front(), what);
        exp_q.delete();
    endtask

    task automatic expect_quiet(input int bits, input string what);
        repeat (bits * CLKS) @(negedge clk);
        check_value(got_q.size(), 0, what);
        got_q.delete();
    endtask

    task automatic report_test(input int num, input string name, input int base);
        tests_run++;
        if (errors != base)
            tests_failed++;
        $display("test %0d %s: %s", num, name, (errors == base) ? "passed" : "failed");
    endtask

    task automatic single_echo_test();
        int base;
        int e0;
        int d0;
        base = errors;
        e0   = err_pulses;
        d0   = drop_pulses;
        check_value(tx, 1, "tx level after reset");
        check_value(rx_error, 0, "rx_error after reset");
        check_value(byte_dropped, 0, "byte_dropped after reset");
        exp_q.push_back(8'h5a);
        send_byte(8'h5a, 1'b0, 1'b0, -1);
        compare_echo(1, 14, "single echo byte");
        check_value(err_pulses - e0, 0, "rx_error pulses");
        check_value(drop_pulses - d0, 0, "byte_dropped pulses");
        report_test(1, "single byte echo", base);
    endtask

    task automatic burst_test();
        int base;
        int e0;
        int d0;
        int i;
        uart_buf_pkg::byte_t data;
        base = errors;
        e0   = err_pulses;
        d0   = drop_pulses;
        // Back to back frames drain slower on tx so the buffer takes up the slack
        for (i = 0; i < 6; i++) begin
            data = 8'($urandom());
            exp_q.push_back(data);
            send_byte(data, 1'b0, 1'b0, -1);
        end
        compare_echo(6, 6 * 12 + 12, "burst byte");
        check_value(err_pulses - e0, 0, "rx_error pulses in burst");
        check_value(drop_pulses - d0, 0, "byte_dropped pulses in burst");
        report_test(2, "random burst", base);
    endtask

    task automatic bad_stop_test();
        int base;
        int e0;
        base = errors;
        e0   = err_pulses;
        send_byte(8'h3c, 1'b1, 1'b0, -1);
        // Receiver holdoff is 2 bit periods
        repeat (2 * CLKS) @(negedge clk);
        check_value(err_pulses - e0, 1, "rx_error pulses after low stop bit");
        exp_q.push_back(8'hc3);
        send_byte(8'hc3, 1'b0, 1'b0, -1);
        compare_echo(1, 14, "byte after framing error");
        expect_quiet(4, "extra bytes after framing error");
        check_value(err_pulses - e0, 1, "rx_error pulses after recovery");
        report_test(3, "low stop bit", base);
    endtask

    task automatic short_start_test();
        int base;
        int e0;
        base = errors;
        e0   = err_pulses;
        send_byte(8'h00, 1'b0, 1'b1, -1);
        expect_quiet(24, "bytes on tx after short start");
        check_value(err_pulses - e0, 1, "rx_error pulses after short start");
        report_test(4, "short start pulse", base);
    endtask

    task automatic glitch_test();
        int base;
        int e0;
        base = errors;
        e0   = err_pulses;
        // A one going low and then a zero going high for one clock each
        exp_q.push_back(8'ha5);
        send_byte(8'ha5, 1'b0, 1'b0, 2);
        exp_q.push_back(8'h0f);
        send_byte(8'h0f, 1'b0, 1'b0, 6);
        compare_echo(2, 2 * 12 + 12, "glitched byte");
        check_value(err_pulses - e0, 0, "rx_error pulses with glitch");
        report_test(5, "single sample glitch", base);
    endtask

    task automatic overflow_test();
        int base;
        int d0;
        int i;
        uart_buf_pkg::byte_t data;
        base = errors;
        d0   = drop_pulses;
        tx_pause = 1'b1;
        // Let any frame in flight finish before filling
        repeat (3 * CLKS) @(negedge clk);
        for (i = 0; i < DEPTH + 2; i++) begin
            data = 8'($urandom());
            if (i < DEPTH)
                exp_q.push_back(data);
            send_byte(data, 1'b0, 1'b0, -1);
        end
        repeat (CLKS) @(negedge clk);
        check_value(drop_pulses - d0, 2, "byte_dropped pulses on overflow");
        check_value(got_q.size(), 0, "bytes on tx while paused");
        tx_pause = 1'b0;
        compare_echo(DEPTH, DEPTH * 12 + 12, "drained byte");
        expect_quiet(24, "extra bytes after drain");
        report_test(6, "overflow under pause", base);
    endtask

    initial begin
        void'($urandom(32'hcf19_789e));
        rst      = 1'b1;
        rx       = 1'b1;
        tx_pause = 1'b0;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        repeat (2 * CLKS) @(negedge clk);
        single_echo_test();
        burst_test();
        bad_stop_test();
        short_start_test();
        glitch_test();
        overflow_test();
        $display("Summary: %0d tests, %0d failed, %0d check errors",
                 tests_run, tests_failed, errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
src/uart_line_pkg.sv
src/uart_buf_pkg.sv
src/buf_port_if.sv
src/uart_rx.sv
src/uart_tx.sv
src/echo_buffer.sv
src/uart_echo_top.sv
tb/uart_echo_props.sv
tb/uart_echo_tb.sv

// ==== Bender.yml ====
package:
  name: uart_echo

sources:
  - files:
      - src/uart_line_pkg.sv
      - src/uart_buf_pkg.sv
      - src/buf_port_if.sv
      - src/uart_rx.sv
      - src/uart_tx.sv
      - src/echo_buffer.sv
      - src/uart_echo_top.sv
  - target: test
    files:
      - tb/uart_echo_props.sv
      - tb/uart_echo_tb.sv
